// File: testbench/dehaze_patterns.hex
// Columns: nine window pixels RRGGBB in raster order, light RRGGBB,
// inverse light for red, green, blue in Q0.16, expected output pixel RRGGBB

// Light 200,200,200
// Uniform darker than A, mixed add and subtract, flat Gaussian window
64788c 64788c 64788c 64788c 64788c 64788c 64788c 64788c 64788c c8c8c8 147 147 147 0c3258
d296cd d296cd d296cd d296cd d296cd d296cd d296cd d296cd d296cd c8c8c8 147 147 147 e920d8
50643c 5a6e46 50643c 5a7846 608240 5a6e46 50643c 5a7846 50643c c8c8c8 147 147 147 316303
// Horizontal and vertical green edges keep the centre
283c50 283c50 283c50 281450 785a96 286450 283c50 283c50 283c50 c8c8c8 147 147 147 3e0a72
323232 320a32 323232 323232 beaa96 323232 323232 32c832 323232 c8c8c8 147 147 147 a76320
// Gradient of exactly 32 is flat, 33 is an edge
646464 646464 646464 645464 643c64 647464 646464 646464 646464 c8c8c8 147 147 147 1c001c
646464 646464 646464 645464 643c64 647564 646464 646464 646464 c8c8c8 147 147 147 3d063d

// Light 240,230,220
// Dense haze hits the transmission floor and clamps high and low
ebe4fa ebe4fa ebe4fa ebe4fa ebe4fa ebe4fa ebe4fa ebe4fa ebe4fa f0e6dc 111 11c 129 bdd2ff
fafafa fafafa fafafa fafafa b4fafa fafafa fafafa fafafa fafafa f0e6dc 111 11c 129 00ffff
// Black minimum gives full transmission
002850 002850 002850 002850 002850 002850 002850 002850 002850 f0e6dc 111 11c 129 002850
64c8d2 64c8d2 64c8d2 64c8d2 64c8d2 64c8d2 64c8d2 64c8d2 64c8d2 f0e6dc 111 11c 129 0bb5cc
// Ties pick red over green, then green over blue
9696b4 9696b4 9696b4 9696b4 9696b4 9696b4 9696b4 9696b4 9696b4 f0e6dc 111 11c 129 17257c
c87878 c87878 c87878 c87878 c87878 c87878 c87878 c87878 c87878 f0e6dc 111 11c 129 a20e18

// Streaming replay with light 200,200,200
50643c 5a6e46 50643c 5a7846 608240 5a6e46 50643c 5a7846 50643c c8c8c8 147 147 147 316303
646464 646464 646464 645464 643c64 647564 646464 646464 646464 c8c8c8 147 147 147 3d063d
64788c 64788c 64788c 64788c 64788c 64788c 64788c 64788c 64788c c8c8c8 147 147 147 0c3258
283c50 283c50 283c50 281450 785a96 286450 283c50 283c50 283c50 c8c8c8 147 147 147 3e0a72
646464 646464 646464 645464 643c64 647464 646464 646464 646464 c8c8c8 147 147 147 1c001c
d296cd d296cd d296cd d296cd d296cd d296cd d296cd d296cd d296cd c8c8c8 147 147 147 e920d8

// Streaming replay with light 240,230,220
fafafa fafafa fafafa fafafa b4fafa fafafa fafafa fafafa fafafa f0e6dc 111 11c 129 00ffff
9696b4 9696b4 9696b4 9696b4 9696b4 9696b4 9696b4 9696b4 9696b4 f0e6dc 111 11c 129 17257c
ebe4fa ebe4fa ebe4fa ebe4fa ebe4fa ebe4fa ebe4fa ebe4fa ebe4fa f0e6dc 111 11c 129 bdd2ff
002850 002850 002850 002850 002850 002850 002850 002850 002850 f0e6dc 111 11c 129 002850
64c8d2 64c8d2 64c8d2 64c8d2 64c8d2 64c8d2 64c8d2 64c8d2 64c8d2 f0e6dc 111 11c 129 0bb5cc

// File: verilog.f
+incdir+rtl
rtl/dehaze_pkg.sv
rtl/pipe_delay.sv
rtl/window_filter.sv
rtl/transmission_estimator.sv
rtl/reciprocal_rom.sv
rtl/scene_recovery.sv
rtl/dehaze_top.sv
testbench/tb_dehaze.sv

// File: Makefile
SIM       := verilator
TOP       := tb_dehaze
FILELIST  := verilog.f
FLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard rtl/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_dehaze.sv
// Testbench for the dehaze pipeline that replays the pattern file and checks every pixel
`timescale 1ns/1ns

module tb_dehaze;
    import dehaze_pkg::*;

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 4;
    localparam int LATENCY       = 6;
    // Nine window pixels, light, three inverses, expected pixel
    localparam int WORDS_PER_VEC = 14;
    localparam int MAX_VECS      = 64;
    localparam int MAX_GAP       = 2;

    logic    clk = 1'b0;
    logic    rst;
    logic    in_valid;
    window_t in_win;
    atmo_t   atmo;
    logic    out_valid;
    rgb_t    out_pix;

    logic [23:0] pattern_mem [MAX_VECS * WORDS_PER_VEC];
    rgb_t        exp_pix_q [$];
    int          exp_cycle_q [$];
    int          cycle_cnt   = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          vec_count   = 0;
    int          seed;
    bit          loaded      = 1'b0;

    dehaze_top u_dehaze_top (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_win    (in_win),
        .atmo      (atmo),
        .out_valid (out_valid),
        .out_pix   (out_pix)
    );

    // ======================================================================
    // Clock and cycle count
    // ======================================================================
    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Top byte ff marks an entry the pattern file did not overwrite
    task automatic fill_pattern_mem();
        for (int k = 0; k < MAX_VECS * WORDS_PER_VEC; k++) begin
            pattern_mem[k] = {8'hff, 16'(k)};
        end
    endtask

    // An inverse word is only 16 bits wide, so a loaded one has a zero top byte
    function automatic int count_vectors();
        int n;
        n = 0;
        while (n < MAX_VECS && pattern_mem[n * WORDS_PER_VEC + 10][23:16] == 8'h00) begin
            n++;
        end
        return n;
    endfunction

    task automatic load_vector(input int v, output window_t win, output atmo_t light,
                               output rgb_t pix);
        int base;
        base = v * WORDS_PER_VEC;
        for (int k = 0; k < 9; k++) begin
            win[k] = pattern_mem[base + k];
        end
        light.a     = pattern_mem[base + 9];
        light.inv_r = pattern_mem[base + 10][15:0];
        light.inv_g = pattern_mem[base + 11][15:0];
        light.inv_b = pattern_mem[base + 12][15:0];
        pix         = pattern_mem[base + 13];
    endtask

    task automatic wait_for_drain();
        while (exp_pix_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_run(input bit timed_out);
        $display("Checked %0d of %0d pixels with %0d errors", check_count, vec_count, error_count);
        if (!timed_out && error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin
        window_t win;
        atmo_t   light;
        rgb_t    expected;
        int      gap;

        seed     = 84740;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_win   = '0;
        atmo     = '0;
        fill_pattern_mem();
        $readmemh("testbench/dehaze_patterns.hex", pattern_mem);
        vec_count = count_vectors();
        loaded    = 1'b1;
        assert (vec_count > 0) else begin
            $display("ERROR: no test vectors were read from the pattern file");
            error_count++;
        end

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        for (int v = 0; v < vec_count; v++) begin
            load_vector(v, win, light, expected);
            // Light feeds two stages a cycle apart, so it changes only on an empty pipe
            if (light != atmo) begin
                wait_for_drain();
            end
            atmo     = light;
            in_win   = win;
            in_valid = 1'b1;
            exp_pix_q.push_back(expected);
            exp_cycle_q.push_back(cycle_cnt);
            @(negedge clk);
            in_valid = 1'b0;
            gap = {$random(seed)} % (MAX_GAP + 1);
            repeat (gap) @(negedge clk);
        end

        wait_for_drain();
        // Catch stray outputs after the last pixel
        repeat (LATENCY + 2) @(negedge clk);
        finish_run(1'b0);
    end

    // ======================================================================
    // Output checking
    // ======================================================================
    always @(negedge clk) begin : check_output
        rgb_t expected;
        int   issued;
        if (out_valid !== 1'b0) begin
            assert (out_valid === 1'b1) else begin
                $display("ERROR at %0t: out_valid is unknown", $time);
                error_count++;
            end
            assert (exp_pix_q.size() > 0) else begin
                $display("ERROR at %0t: out_valid is high with no window in flight", $time);
                error_count++;
            end
            if (exp_pix_q.size() > 0) begin
                expected = exp_pix_q.pop_front();
                issued   = exp_cycle_q.pop_front();
                check_count++;
                assert (cycle_cnt == issued + LATENCY) else begin
                    $display("Mismatch at %0t: pixel came %0d cycles after its window, not %0d",
                             $time, cycle_cnt - issued, LATENCY);
                    error_count++;
                end
                assert (out_pix === expected) else begin
                    $display("Mismatch at %0t: got r=%0d g=%0d b=%0d, expected r=%0d g=%0d b=%0d",
                             $time, out_pix.r, out_pix.g, out_pix.b,
                             expected.r, expected.g, expected.b);
                    error_count++;
                end
            end
        end
    end

    // Watchdog sized from the vector count
    initial begin
        int limit;
        wait (loaded);
        limit = vec_count * 4 + 50;
        repeat (limit) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles with %0d pixels still expected",
                 limit, exp_pix_q.size());
        finish_run(1'b1);
    end

endmodule

// File: rtl/dehaze_top.sv
// Top level of the haze-removal back end taking one window per valid cycle and returning pixels
`timescale 1ns/1ns
`include "dehaze_defines.svh"

module dehaze_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  dehaze_pkg::window_t in_win,
    input  dehaze_pkg::atmo_t   atmo,
    output logic                out_valid,
    output dehaze_pkg::rgb_t    out_pix
);

    // Filter 1 + transmission 2 + lookup 1
    localparam int SIDE_DEPTH  = 4;
    // Adds the two recovery cycles
    localparam int VALID_DEPTH = 6;

    dehaze_pkg::rgb_t    filt;
    logic [`T_W-1:0]     t;
    logic [`RECIP_W-1:0] recip;
    dehaze_pkg::recov_t  side_in;
    dehaze_pkg::recov_t  side_out;

    // Centre pixel and light ride alongside the transmission path
    assign side_in.i = in_win[4];
    assign side_in.a = atmo.a;

    // ======================================================================
    // Transmission path
    // ======================================================================
    window_filter u_filter (
        .clk  (clk),
        .rst  (rst),
        .win  (in_win),
        .filt (filt)
    );

    transmission_estimator u_trans (
        .clk  (clk),
        .rst  (rst),
        .filt (filt),
        .atmo (atmo),
        .t    (t)
    );

    reciprocal_rom u_recip (
        .clk   (clk),
        .rst   (rst),
        .t     (t),
        .recip (recip)
    );

    // ======================================================================
    // Side data, recovery and valid tracking
    // ======================================================================
    pipe_delay #(
        .data_t (dehaze_pkg::recov_t),
        .DEPTH  (SIDE_DEPTH)
    ) u_side_delay (
        .clk (clk),
        .rst (rst),
        .d   (side_in),
        .q   (side_out)
    );

    scene_recovery u_recov (
        .clk   (clk),
        .rst   (rst),
        .side  (side_out),
        .recip (recip),
        .pix   (out_pix)
    );

    pipe_delay #(
        .data_t (logic),
        .DEPTH  (VALID_DEPTH)
    ) u_valid_delay (
        .clk (clk),
        .rst (rst),
        .d   (in_valid),
        .q   (out_valid)
    );

endmodule

// File: rtl/scene_recovery.sv
// Last dehaze stage that recovers radiance as A +/- |I - A|/t and clamps it to 8 bits
`timescale 1ns/1ns
`include "dehaze_defines.svh"

module scene_recovery (
    input  logic                clk,
    input  logic                rst,
    input  dehaze_pkg::recov_t  side,
    input  logic [`RECIP_W-1:0] recip,
    output dehaze_pkg::rgb_t    pix
);
    import dehaze_pkg::*;

    localparam int PROD_W = `PIX_W + `RECIP_W;
    localparam int QUOT_W = PROD_W - `RECIP_FRAC;
    localparam logic [`PIX_W-1:0] PIX_MAX = '1;

    rgb_t       scaled;
    logic [2:0] bright;
    rgb_t       scaled_q;
    rgb_t       a_q;
    logic [2:0] bright_q;
    rgb_t       radiance;

    // |I - A| * (1/t), saturated to one channel
    function automatic logic [`PIX_W-1:0] scale_diff(input logic [`PIX_W-1:0] i,
                                                     input logic [`PIX_W-1:0] a,
                                                     input logic [`RECIP_W-1:0] r);
        logic [`PIX_W-1:0] diff;
        logic [PROD_W-1:0] prod;
        logic [QUOT_W-1:0] quot;
        diff = (i >= a) ? i - a : a - i;
        prod = diff * r;
        quot = prod[PROD_W-1:`RECIP_FRAC];
        return (quot > PIX_MAX) ? PIX_MAX : quot[`PIX_W-1:0];
    endfunction

    // Move away from A in the direction I lies, clamped to 0..255
    function automatic logic [`PIX_W-1:0] recover(input logic [`PIX_W-1:0] a,
                                                  input logic [`PIX_W-1:0] s,
                                                  input logic up);
        logic [`PIX_W:0] sum;
        sum = {1'b0, a} + {1'b0, s};
        if (up) begin
            return sum[`PIX_W] ? PIX_MAX : sum[`PIX_W-1:0];
        end
        return (s > a) ? '0 : a - s;
    endfunction

    always_comb begin
        scaled.r = scale_diff(side.i.r, side.a.r, recip);
        scaled.g = scale_diff(side.i.g, side.a.g, recip);
        scaled.b = scale_diff(side.i.b, side.a.b, recip);
        bright   = {side.i.r >= side.a.r, side.i.g >= side.a.g, side.i.b >= side.a.b};

        radiance.r = recover(a_q.r, scaled_q.r, bright_q[2]);
        radiance.g = recover(a_q.g, scaled_q.g, bright_q[1]);
        radiance.b = recover(a_q.b, scaled_q.b, bright_q[0]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            scaled_q <= '0;
            a_q      <= '0;
            bright_q <= '0;
            pix      <= '0;
        end else begin
            scaled_q <= scaled;
            a_q      <= side.a;
            bright_q <= bright;
            pix      <= radiance;
        end
    end

endmodule

// File: rtl/reciprocal_rom.sv
// Lookup stage that converts a Q0.14 transmission into its reciprocal for scene recovery
`timescale 1ns/1ns
`include "dehaze_defines.svh"

module reciprocal_rom (
    input  logic                clk,
    input  logic                rst,
    input  logic [`T_W-1:0]     t,
    output logic [`RECIP_W-1:0] recip
);

    localparam int IDX_SHIFT = 6;
    localparam int IDX_W     = `T_W - IDX_SHIFT;
    localparam int DEPTH     = 1 << IDX_W;
    localparam int IDX_MIN   = `T_MIN >> IDX_SHIFT;
    // Entry k is 1/(k / 2^IDX_W) scaled by 2^RECIP_FRAC
    localparam int RECIP_NUM = 1 << (IDX_W + `RECIP_FRAC);

    logic [`RECIP_W-1:0] rom [DEPTH];
    logic [IDX_W-1:0]    idx;

    // Indices under the transmission floor never occur
    function automatic logic [`RECIP_W-1:0] recip_entry(input int k);
        if (k < IDX_MIN) begin
            return '0;
        end
        return `RECIP_W'(RECIP_NUM / k);
    endfunction

    for (genvar k = 0; k < DEPTH; k++) begin : g_rom
        assign rom[k] = recip_entry(k);
    end

    assign idx = t[`T_W-1:IDX_SHIFT];

    always_ff @(posedge clk) begin
        if (rst) begin
            recip <= '0;
        end else begin
            recip <= rom[idx];
        end
    end

    // Relies on the floor applied by the transmission stage
    a_idx_floor: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> idx >= IDX_MIN);

endmodule

// File: rtl/transmission_estimator.sv
// Transmission stage that turns the darkest filtered channel into a bounded Q0.14 transmission
`timescale 1ns/1ns
`include "dehaze_defines.svh"

module transmission_estimator (
    input  logic              clk,
    input  logic              rst,
    input  dehaze_pkg::rgb_t  filt,
    input  dehaze_pkg::atmo_t atmo,
    output logic [`T_W-1:0]   t
);

    localparam int PROD_W  = `INV_W + `PIX_W;
    // Q0.16 product down to Q0.14
    localparam int Q_SHIFT = `INV_W - `T_W;
    localparam logic [`T_W-1:0] T_MAX = '1;
    localparam logic [`T_W:0]   T_ONE = 1 << `T_W;
    // Unity in the Q0.16 format of the inverse light
    localparam logic [PROD_W:0] INV_ONE = 1 << `INV_W;

    logic [`PIX_W-1:0]          f_min;
    logic [`INV_W-1:0]          inv_min;
    logic [`INV_W-1:0]          inv_scaled;
    logic [PROD_W-1:0]          prod_full;
    logic [PROD_W-Q_SHIFT-1:0]  prod_q14;
    logic [`T_W-1:0]            prod_sat;
    logic [`T_W-1:0]            prod_q;
    logic [`T_W:0]              t_raw;
    logic [`T_W-1:0]            t_next;

    // Inverse within one step of 2^16 / A
    function automatic logic inv_matches(input logic [`PIX_W-1:0] a,
                                         input logic [`INV_W-1:0] inv);
        logic [PROD_W:0] prod;
        prod = a * inv;
        return (prod + a > INV_ONE) && (prod < INV_ONE + a);
    endfunction

    // ======================================================================
    // Cycle 1, dark channel times omega over A
    // ======================================================================
    always_comb begin
        // Ties go to red, then green
        if (filt.r <= filt.g && filt.r <= filt.b) begin
            f_min   = filt.r;
            inv_min = atmo.inv_r;
        end else if (filt.g <= filt.b) begin
            f_min   = filt.g;
            inv_min = atmo.inv_g;
        end else begin
            f_min   = filt.b;
            inv_min = atmo.inv_b;
        end
        inv_scaled = inv_min - (inv_min >> `OMEGA_SHIFT);
        prod_full  = inv_scaled * f_min;
        prod_q14   = prod_full[PROD_W-1:Q_SHIFT];
        prod_sat   = (prod_q14 > T_MAX) ? T_MAX : prod_q14[`T_W-1:0];
    end

    // ======================================================================
    // Cycle 2, t = 1 - product with a floor
    // ======================================================================
    always_comb begin
        t_raw = T_ONE - {1'b0, prod_q};
        if (t_raw[`T_W]) begin
            // Full unity does not fit in Q0.14
            t_next = T_MAX;
        end else if (t_raw < `T_MIN) begin
            t_next = `T_MIN;
        end else begin
            t_next = t_raw[`T_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_q <= '0;
            t      <= '0;
        end else begin
            prod_q <= prod_sat;
            t      <= t_next;
        end
    end

    // The product only estimates I/A when each inverse belongs to its light
    a_inv_match: assert property (@(posedge clk) disable iff (rst)
        inv_matches(atmo.a.r, atmo.inv_r) && inv_matches(atmo.a.g, atmo.inv_g) &&
        inv_matches(atmo.a.b, atmo.inv_b));

endmodule

// File: rtl/window_filter.sv
// First dehaze stage that smooths each colour of a 3x3 window unless the green channel shows an edge
`timescale 1ns/1ns
`include "dehaze_defines.svh"

module window_filter (
    input  logic                clk,
    input  logic                rst,
    input  dehaze_pkg::window_t win,
    output dehaze_pkg::rgb_t    filt
);
    import dehaze_pkg::*;

    // Raster positions inside the window
    localparam int UP    = 1;
    localparam int LEFT  = 3;
    localparam int CTR   = 4;
    localparam int RIGHT = 5;
    localparam int DOWN  = 7;

    // Gaussian weights sum to 16
    localparam int ACC_W = `PIX_W + 4;

    logic [0:8][`PIX_W-1:0] ch_r;
    logic [0:8][`PIX_W-1:0] ch_g;
    logic [0:8][`PIX_W-1:0] ch_b;
    logic [`PIX_W-1:0]      grad_h;
    logic [`PIX_W-1:0]      grad_v;
    logic                   is_edge;
    rgb_t                   smooth;

    function automatic logic [`PIX_W-1:0] abs_diff(input logic [`PIX_W-1:0] x,
                                                   input logic [`PIX_W-1:0] y);
        return (x >= y) ? x - y : y - x;
    endfunction

    // 1-2-1 / 2-4-2 / 1-2-1 kernel, normalised by 16
    function automatic logic [`PIX_W-1:0] gauss3x3(input logic [0:8][`PIX_W-1:0] p);
        logic [ACC_W-1:0] acc;
        acc = ACC_W'(p[0]) + ACC_W'(p[2]) + ACC_W'(p[6]) + ACC_W'(p[8]);
        acc = acc + (ACC_W'(p[1]) << 1) + (ACC_W'(p[3]) << 1);
        acc = acc + (ACC_W'(p[5]) << 1) + (ACC_W'(p[7]) << 1);
        acc = acc + (ACC_W'(p[4]) << 2);
        return acc[ACC_W-1:4];
    endfunction

    // Split the window into per-channel planes
    always_comb begin
        for (int k = 0; k < 9; k++) begin
            ch_r[k] = win[k].r;
            ch_g[k] = win[k].g;
            ch_b[k] = win[k].b;
        end
    end

    // ======================================================================
    // Edge decision from green gradients
    // ======================================================================
    assign grad_h  = abs_diff(win[LEFT].g, win[RIGHT].g);
    assign grad_v  = abs_diff(win[UP].g, win[DOWN].g);
    assign is_edge = (grad_h > `EDGE_THRESH) || (grad_v > `EDGE_THRESH);

    // Edges keep the centre so detail is not blurred
    always_comb begin
        smooth.r = is_edge ? win[CTR].r : gauss3x3(ch_r);
        smooth.g = is_edge ? win[CTR].g : gauss3x3(ch_g);
        smooth.b = is_edge ? win[CTR].b : gauss3x3(ch_b);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            filt <= '0;
        end else begin
            filt <= smooth;
        end
    end

endmodule

// File: rtl/pipe_delay.sv
// Register chain of fixed depth that keeps side data aligned with the pipeline stages
`timescale 1ns/1ns

module pipe_delay #(
    parameter type data_t = logic,
    parameter int  DEPTH  = 1
) (
    input  logic  clk,
    input  logic  rst,
    input  data_t d,
    output data_t q
);

    data_t stage [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < DEPTH; k++) begin
                stage[k] <= '0;
            end
        end else begin
            stage[0] <= d;
            // Shift towards the output
            for (int k = 1; k < DEPTH; k++) begin
                stage[k] <= stage[k-1];
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

// File: rtl/dehaze_pkg.sv
// Pixel, window and light types shared by the dehaze stages and the testbench
`include "dehaze_defines.svh"

package dehaze_pkg;

    // ======================================================================
    // Pixel level types
    // ======================================================================

    // One RGB pixel with red in the top byte
    typedef struct packed {
        logic [`PIX_W-1:0] r;
        logic [`PIX_W-1:0] g;
        logic [`PIX_W-1:0] b;
    } rgb_t;

    // 3x3 neighbourhood in raster order
    // Element 0 is top left and sits in the top bits, element 4 is the centre
    typedef rgb_t [0:8] window_t;

    // ======================================================================
    // Light and side data
    // ======================================================================

    // Atmospheric light and its per-channel inverse in Q0.16
    typedef struct packed {
        rgb_t              a;
        logic [`INV_W-1:0] inv_r;
        logic [`INV_W-1:0] inv_g;
        logic [`INV_W-1:0] inv_b;
    } atmo_t;

    // Centre pixel and light waiting for the transmission
    typedef struct packed {
        rgb_t i;
        rgb_t a;
    } recov_t;

endpackage

// File: rtl/dehaze_defines.svh
// Width and constant macros for the dehaze pipeline, included by the package and stage modules
`ifndef DEHAZE_DEFINES_SVH
`define DEHAZE_DEFINES_SVH

// Channel width of one colour component
`define PIX_W 8

// Inverse atmospheric light, Q0.16
`define INV_W 16

// Transmission, Q0.14
`define T_W 14

// Reciprocal of transmission with RECIP_FRAC fraction bits
`define RECIP_W 14
`define RECIP_FRAC 10

// Haze weight omega = 1 - 2^-OMEGA_SHIFT
`define OMEGA_SHIFT 4

// Lower bound on transmission, roughly 0.1 in Q0.14
`define T_MIN 1638

// Green gradient above which a window counts as an edge
`define EDGE_THRESH 32

`endif
